// ==== Bender.yml ====
package:
  name: sseg

sources:
  - sseg_pkg.sv
  - bintobcd.sv
  - sseg4.sv
  - sseg_decode.sv
  - sseg_scan.sv
  - sseg_top.sv
  - target: test
    files:
      - tb_sseg.sv

// ==== bintobcd.sv ====
`timescale 1ns/1ps

module bintobcd
    (
        input   logic i_clk,
        input   logic i_rst,
        input   logic i_start,
        input   logic [sseg_pkg::LP_BIN_W-1:0] i_bin,

        output  logic o_ready,
        output  logic o_done,
        output  logic [3:0] o_bcd3,
        output  logic [3:0] o_bcd2,
        output  logic [3:0] o_bcd1,
        output  logic [3:0] o_bcd0
    );

    import sseg_pkg::*;

    typedef enum logic {e_idle, e_shift} t_state;
    t_state r_state;

    logic [$clog2(LP_BIN_W)-1:0] r_cnt;
    logic r_done;

    // BCD digits on top, binary value below
    logic [4*LP_DIGITS+LP_BIN_W-1:0] r_sr;
    logic [4*LP_DIGITS+LP_BIN_W-1:0] w_adj;

    // ****************************************
    // Control
    // ****************************************

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_cnt <= '0;
            r_done <= 1'b0;
        end
        else
        begin
            r_done <= 1'b0;
            case (r_state)
                e_idle:
                begin
                    if (i_start)
                    begin
                        r_cnt <= '0;
                        r_state <= e_shift;
                    end
                end
                e_shift:
                begin
                    r_cnt <= r_cnt + 1'b1;
                    // Last of the shifts
                    if (r_cnt == ($clog2(LP_BIN_W))'(LP_BIN_W - 1))
                    begin
                        r_state <= e_idle;
                        r_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // ****************************************
    // Add-3 and shift
    // ****************************************

    always_comb
    begin
        w_adj = r_sr;
        for (int i = 0; i < LP_DIGITS; i++)
        begin
            if (w_adj[LP_BIN_W+4*i +: 4] >= 4'd5)
                w_adj[LP_BIN_W+4*i +: 4] = w_adj[LP_BIN_W+4*i +: 4] + 4'd3;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (r_state == e_idle && i_start)
            r_sr <= {{(4*LP_DIGITS){1'b0}}, i_bin};
        else if (r_state == e_shift)
            r_sr <= {w_adj[4*LP_DIGITS+LP_BIN_W-2:0], 1'b0};
    end

    assign o_ready = (r_state == e_idle);
    assign o_done = r_done;

    assign o_bcd3 = r_sr[LP_BIN_W+12 +: 4];
    assign o_bcd2 = r_sr[LP_BIN_W+8 +: 4];
    assign o_bcd1 = r_sr[LP_BIN_W+4 +: 4];
    assign o_bcd0 = r_sr[LP_BIN_W +: 4];

    // Controller waits for ready before starting
    a_start_when_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        i_start |-> o_ready);

endmodule

// ==== project.f ====
sseg_pkg.sv
bintobcd.sv
sseg4.sv
sseg_decode.sv
sseg_scan.sv
sseg_top.sv
tb_sseg.sv

// ==== sseg4.sv ====
`timescale 1ns/1ps

module sseg4
    (
        input   logic i_clk,
        input   logic i_rst,
        input   logic [sseg_pkg::LP_BIN_W-1:0] i_bin,
        input   logic i_greeting,

        // Converter side
        input   logic i_conv_ready,
        input   logic i_conv_done,
        input   logic [3:0] i_bcd3,
        input   logic [3:0] i_bcd2,
        input   logic [3:0] i_bcd1,
        input   logic [3:0] i_bcd0,
        output  logic o_conv_start,
        output  logic [sseg_pkg::LP_BIN_W-1:0] o_conv_bin,

        // Glyphs to the scanner, digit 0 on the right
        output  logic [sseg_pkg::LP_GLYPH_W-1:0] o_glyph3,
        output  logic [sseg_pkg::LP_GLYPH_W-1:0] o_glyph2,
        output  logic [sseg_pkg::LP_GLYPH_W-1:0] o_glyph1,
        output  logic [sseg_pkg::LP_GLYPH_W-1:0] o_glyph0,
        output  logic o_idle
    );

    import sseg_pkg::*;

    typedef enum logic {e_idle, e_change} t_state;
    t_state r_state, w_state_next;

    logic r_greeting, w_greeting_next;

    logic [LP_GLYPH_W-1:0] r_glyph3, r_glyph2, r_glyph1, r_glyph0;
    logic [LP_GLYPH_W-1:0] w_glyph3_next, w_glyph2_next, w_glyph1_next, w_glyph0_next;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state <= e_idle;
            r_greeting <= 1'b0;
            r_glyph3 <= '0;
            r_glyph2 <= '0;
            r_glyph1 <= '0;
            r_glyph0 <= '0;
        end
        else
        begin
            r_state <= w_state_next;
            r_greeting <= w_greeting_next;
            r_glyph3 <= w_glyph3_next;
            r_glyph2 <= w_glyph2_next;
            r_glyph1 <= w_glyph1_next;
            r_glyph0 <= w_glyph0_next;
        end
    end

    // Clamp out-of-range input, the converter latches it on start
    assign o_conv_bin = (i_bin > LP_BIN_MAX) ? LP_BIN_MAX : i_bin;

    always_comb
    begin
        w_state_next = r_state;
        w_greeting_next = r_greeting;
        w_glyph3_next = r_glyph3;
        w_glyph2_next = r_glyph2;
        w_glyph1_next = r_glyph1;
        w_glyph0_next = r_glyph0;
        o_conv_start = 1'b0;

        case (r_state)
            e_idle:
            begin
                if (i_conv_ready)
                begin
                    w_greeting_next = i_greeting;
                    o_conv_start = 1'b1;
                    w_state_next = e_change;
                end
            end
            e_change:
            begin
                if (i_conv_done)
                begin
                    if (r_greeting)
                    begin
                        w_glyph3_next = LP_GLYPH_BLANK;
                        w_glyph2_next = LP_GLYPH_BLANK;
                        w_glyph1_next = LP_GLYPH_H;
                        w_glyph0_next = LP_GLYPH_I;
                    end
                    else
                    begin
                        w_glyph3_next = i_bcd3;
                        w_glyph2_next = i_bcd2;
                        w_glyph1_next = i_bcd1;
                        w_glyph0_next = i_bcd0;
                    end
                    w_state_next = e_idle;
                end
            end
        endcase
    end

    assign o_idle = (r_state == e_idle);

    assign o_glyph3 = r_glyph3;
    assign o_glyph2 = r_glyph2;
    assign o_glyph1 = r_glyph1;
    assign o_glyph0 = r_glyph0;

    // Done only answers a start issued from here
    a_done_in_change: assert property (@(posedge i_clk) disable iff (i_rst)
        i_conv_done |-> r_state == e_change);

endmodule

// ==== sseg_decode.sv ====
`timescale 1ns/1ps

module sseg_decode
    (
        input   logic [sseg_pkg::LP_GLYPH_W-1:0] i_glyph,

        // Bit order g down to a, active low
        output  logic [6:0] o_seg_n
    );

    import sseg_pkg::*;

    always_comb
    begin
        case (i_glyph)
            4'd0:
                o_seg_n = 7'b1000000;
            4'd1:
                o_seg_n = 7'b1111001;
            4'd2:
                o_seg_n = 7'b0100100;
            4'd3:
                o_seg_n = 7'b0110000;
            4'd4:
                o_seg_n = 7'b0011001;
            4'd5:
                o_seg_n = 7'b0010010;
            4'd6:
                o_seg_n = 7'b0000010;
            4'd7:
                o_seg_n = 7'b1111000;
            4'd8:
                o_seg_n = 7'b0000000;
            4'd9:
                o_seg_n = 7'b0010000;
            LP_GLYPH_H:
                o_seg_n = 7'b0001001;
            // Left segments so it differs from 1
            LP_GLYPH_I:
                o_seg_n = 7'b1001111;
            // Blank and unused codes
            default:
                o_seg_n = 7'b1111111;
        endcase
    end

endmodule

// ==== sseg_pkg.sv ====
package sseg_pkg;

    // ****************************************
    // Binary input
    // ****************************************

    // Wide enough for 9999
    localparam int LP_BIN_W = 14;

    // Larger inputs are clamped to this
    localparam logic [LP_BIN_W-1:0] LP_BIN_MAX = 14'd9999;

    // ****************************************
    // Glyph codes
    // ****************************************

    localparam int LP_GLYPH_W = 4;

    // Codes 0 to 9 are the decimal digits
    localparam logic [LP_GLYPH_W-1:0] LP_GLYPH_H = 4'd10;
    localparam logic [LP_GLYPH_W-1:0] LP_GLYPH_I = 4'd11;
    localparam logic [LP_GLYPH_W-1:0] LP_GLYPH_BLANK = 4'd15;

    // ****************************************
    // Display and scan
    // ****************************************

    localparam int LP_DIGITS = 4;

    // Each digit lit for 2**LP_SCAN_BITS cycles
    localparam int LP_SCAN_BITS = 4;

endpackage

// ==== sseg_scan.sv ====
`timescale 1ns/1ps

module sseg_scan
    (
        input   logic i_clk,
        input   logic i_rst,
        input   logic [sseg_pkg::LP_GLYPH_W-1:0] i_glyph3,
        input   logic [sseg_pkg::LP_GLYPH_W-1:0] i_glyph2,
        input   logic [sseg_pkg::LP_GLYPH_W-1:0] i_glyph1,
        input   logic [sseg_pkg::LP_GLYPH_W-1:0] i_glyph0,

        // Decoder loop
        input   logic [6:0] i_seg_n,
        output  logic [sseg_pkg::LP_GLYPH_W-1:0] o_glyph,

        output  logic [sseg_pkg::LP_DIGITS-1:0] o_an_n,
        output  logic [6:0] o_sseg_n
    );

    import sseg_pkg::*;

    logic [LP_SCAN_BITS-1:0] r_cnt;
    logic [$clog2(LP_DIGITS)-1:0] r_digit;
    logic [LP_GLYPH_W-1:0] w_glyphs [LP_DIGITS];

    logic [LP_DIGITS-1:0] r_an_n;
    logic [6:0] r_sseg_n;

    // ****************************************
    // Refresh counter and digit select
    // ****************************************

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_cnt <= '0;
            r_digit <= '0;
        end
        else
        begin
            r_cnt <= r_cnt + 1'b1;
            if (r_cnt == '1)
            begin
                if (r_digit == ($clog2(LP_DIGITS))'(LP_DIGITS - 1))
                    r_digit <= '0;
                else
                    r_digit <= r_digit + 1'b1;
            end
        end
    end

    assign w_glyphs[0] = i_glyph0;
    assign w_glyphs[1] = i_glyph1;
    assign w_glyphs[2] = i_glyph2;
    assign w_glyphs[3] = i_glyph3;

    assign o_glyph = w_glyphs[r_digit];

    // ****************************************
    // Output drive
    // ****************************************

    // Anodes and segments move on the same edge
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_an_n <= '1;
            r_sseg_n <= '1;
        end
        else
        begin
            r_an_n <= ~({{(LP_DIGITS-1){1'b0}}, 1'b1} << r_digit);
            r_sseg_n <= i_seg_n;
        end
    end

    assign o_an_n = r_an_n;
    assign o_sseg_n = r_sseg_n;

    a_one_anode: assert property (@(posedge i_clk) disable iff (i_rst)
        $onehot0(~o_an_n));

endmodule

// ==== sseg_top.sv ====
`timescale 1ns/1ps

module sseg_top
    (
        input   logic i_clk,
        input   logic i_rst,
        input   logic [sseg_pkg::LP_BIN_W-1:0] i_bin,
        input   logic i_greeting,

        output  logic [sseg_pkg::LP_DIGITS-1:0] o_an_n,
        output  logic [6:0] o_sseg_n,
        output  logic o_idle
    );

    import sseg_pkg::*;

    logic w_conv_start, w_conv_ready, w_conv_done;
    logic [LP_BIN_W-1:0] w_conv_bin;
    logic [3:0] w_bcd3, w_bcd2, w_bcd1, w_bcd0;

    logic [LP_GLYPH_W-1:0] w_glyph3, w_glyph2, w_glyph1, w_glyph0;
    logic [LP_GLYPH_W-1:0] w_glyph_sel;
    logic [6:0] w_seg_n;

    sseg4 u_ctrl
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_bin(i_bin), .i_greeting(i_greeting),
        .i_conv_ready(w_conv_ready), .i_conv_done(w_conv_done),
        .i_bcd3(w_bcd3), .i_bcd2(w_bcd2), .i_bcd1(w_bcd1), .i_bcd0(w_bcd0),
        .o_conv_start(w_conv_start), .o_conv_bin(w_conv_bin),
        .o_glyph3(w_glyph3), .o_glyph2(w_glyph2),
        .o_glyph1(w_glyph1), .o_glyph0(w_glyph0),
        .o_idle(o_idle)
    );

    bintobcd u_bintobcd
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_conv_start), .i_bin(w_conv_bin),
        .o_ready(w_conv_ready), .o_done(w_conv_done),
        .o_bcd3(w_bcd3), .o_bcd2(w_bcd2), .o_bcd1(w_bcd1), .o_bcd0(w_bcd0)
    );

    sseg_scan u_scan
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_glyph3(w_glyph3), .i_glyph2(w_glyph2),
        .i_glyph1(w_glyph1), .i_glyph0(w_glyph0),
        .i_seg_n(w_seg_n), .o_glyph(w_glyph_sel),
        .o_an_n(o_an_n), .o_sseg_n(o_sseg_n)
    );

    sseg_decode u_decode
    (
        .i_glyph(w_glyph_sel),
        .o_seg_n(w_seg_n)
    );

endmodule

// ==== tb_sseg.sv ====
`timescale 1ns/1ps

module tb_sseg;

    import sseg_pkg::*;

    localparam int LP_PERIOD = 100;
    localparam int LP_SETTINGS = 40;
    localparam int LP_DIGIT_CYCLES = 2 ** LP_SCAN_BITS;
    localparam int LP_SCAN_LEN = LP_DIGITS * LP_DIGIT_CYCLES;

    logic i_clk = 1'b0;
    logic i_rst;
    logic [LP_BIN_W-1:0] i_bin;
    logic i_greeting;
    logic [LP_DIGITS-1:0] o_an_n;
    logic [6:0] o_sseg_n;
    logic o_idle;

    logic [7*LP_DIGITS-1:0] exp_disp;
    logic chk_en = 1'b0;
    int lit_cnt [LP_DIGITS];
    integer seed = 32'h4a02;

    sseg_top dut0
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_bin(i_bin), .i_greeting(i_greeting),
        .o_an_n(o_an_n), .o_sseg_n(o_sseg_n), .o_idle(o_idle)
    );

    always #(LP_PERIOD/2) i_clk = ~i_clk;

    // ****************************************
    // Reference model
    // ****************************************

    // Lit segments per glyph with a the top bar and g the middle one
    function automatic logic [6:0] seg_pattern(input logic [3:0] glyph);
        string segs;
        logic [6:0] pat;
        case (glyph)
            4'd0: segs = "abcdef";
            4'd1: segs = "bc";
            4'd2: segs = "abdeg";
            4'd3: segs = "abcdg";
            4'd4: segs = "bcfg";
            4'd5: segs = "acdfg";
            4'd6: segs = "acdefg";
            4'd7: segs = "abc";
            4'd8: segs = "abcdefg";
            4'd9: segs = "abcdfg";
            LP_GLYPH_H: segs = "bcefg";
            LP_GLYPH_I: segs = "ef";
            default: segs = "";
        endcase
        pat = '1;
        for (int i = 0; i < segs.len(); i++)
            pat[int'(segs[i]) - 97] = 1'b0;
        return pat;
    endfunction

    // Digit 0 in the low seven bits
    function automatic logic [7*LP_DIGITS-1:0] ref_display(input int value, input bit greeting);
        logic [7*LP_DIGITS-1:0] disp;
        int v;
        v = (value > 9999) ? 9999 : value;
        for (int i = 0; i < LP_DIGITS; i++)
        begin
            disp[7*i +: 7] = seg_pattern(4'(v % 10));
            v = v / 10;
        end
        if (greeting)
            disp = {seg_pattern(LP_GLYPH_BLANK), seg_pattern(LP_GLYPH_BLANK),
                    seg_pattern(LP_GLYPH_H), seg_pattern(LP_GLYPH_I)};
        return disp;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // ****************************************
    // Comparison against the model
    // ****************************************

    always @(negedge i_clk)
    begin : compare
        int idx;
        int lows;
        if (chk_en)
        begin
            idx = 0;
            lows = 0;
            for (int i = 0; i < LP_DIGITS; i++)
            begin
                if (o_an_n[i] === 1'b0)
                begin
                    idx = i;
                    lows++;
                end
            end
            assert (lows == 1) else fail_now($sformatf(
                "error at %0t ns: o_an_n expected one low bit, actual %b", $time, o_an_n));
            assert (o_sseg_n === exp_disp[7*idx +: 7]) else fail_now($sformatf(
                "error at %0t ns: o_sseg_n digit %0d expected %b actual %b",
                $time, idx, exp_disp[7*idx +: 7], o_sseg_n));
            lit_cnt[idx]++;
        end
    end

    initial
    begin
        #(LP_SETTINGS * 200 * LP_PERIOD);
        $display("timeout: the display checks did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

    // ****************************************
    // Stimulus
    // ****************************************

    task automatic apply(input int value, input bit greeting);
        @(posedge i_clk);
        i_bin <= LP_BIN_W'(value);
        i_greeting <= greeting;
    endtask

    task automatic wait_idle(input logic level);
        @(negedge i_clk);
        while (o_idle !== level)
            @(negedge i_clk);
    endtask

    // Ends when glyphs hold a sample taken after the call
    task automatic wait_update();
        wait_idle(1'b1);
        wait_idle(1'b0);
        wait_idle(1'b1);
    endtask

    task automatic check_window(input int value, input bit greeting, input int cycles);
        @(posedge i_clk);
        exp_disp = ref_display(value, greeting);
        foreach (lit_cnt[i])
            lit_cnt[i] = 0;
        chk_en = 1'b1;
        repeat (cycles) @(posedge i_clk);
        chk_en = 1'b0;
    endtask

    task automatic check_value(input int value, input bit greeting);
        apply(value, greeting);
        wait_update();
        check_window(value, greeting, LP_SCAN_LEN);
        foreach (lit_cnt[i])
            assert (lit_cnt[i] == LP_DIGIT_CYCLES) else fail_now($sformatf(
                "error at %0t ns: o_an_n[%0d] low cycles expected %0d actual %0d",
                $time, i, LP_DIGIT_CYCLES, lit_cnt[i]));
    endtask

    task automatic check_first_scan();
        @(negedge i_clk);
        assert (o_an_n === '1) else fail_now($sformatf(
            "error at %0t ns: o_an_n expected 1111 actual %b", $time, o_an_n));
        assert (o_idle === 1'b1) else fail_now($sformatf(
            "error at %0t ns: o_idle expected 1 actual %b", $time, o_idle));
        fork
            check_window(0, 1'b0, LP_SCAN_LEN);
            for (int k = 0; k < LP_SCAN_LEN; k++)
            begin
                @(negedge i_clk);
                assert (o_an_n === ~(4'b0001 << (k / LP_DIGIT_CYCLES))) else fail_now(
                    $sformatf("error at %0t ns: o_an_n expected %b actual %b", $time,
                    ~(4'b0001 << (k / LP_DIGIT_CYCLES)), o_an_n));
            end
        join
    endtask

    initial
    begin
        int fixed [6];
        int rnd;
        fixed = '{0, 7, 10, 99, 1234, 9999};
        i_rst = 1'b1;
        i_bin = '0;
        i_greeting = 1'b0;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        check_first_scan();

        foreach (fixed[i])
            check_value(fixed[i], 1'b0);
        repeat (30)
        begin
            rnd = $unsigned($random(seed)) % 10000;
            check_value(rnd, 1'b0);
        end

        // Out of range values are clamped
        check_value(10000, 1'b0);
        check_value(16383, 1'b0);

        check_value(1234, 1'b1);
        check_value(16383, 1'b1);
        check_value(1234, 1'b0);

        // New value arrives in the middle of a conversion
        apply(4321, 1'b0);
        wait_idle(1'b1);
        wait_idle(1'b0);
        @(posedge i_clk);
        i_bin <= LP_BIN_W'(5678);
        wait_idle(1'b1);
        check_window(4321, 1'b0, LP_DIGIT_CYCLES - 1);
        wait_update();
        check_window(5678, 1'b0, LP_SCAN_LEN);

        $display("** PASS **");
        $finish;
    end

endmodule
